//--- csr_access_ctrl.sv
`timescale 1ns/100ps

`include "csr_defines.svh"

module csr_access_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  csr_pkg::csr_req_t      req_i,
  input  logic                   req_valid_i,
  output logic                   ack_o,
  output csr_pkg::csr_rsp_t      rsp_o,
  output logic [`CSR_ADDR_W-1:0] raddr_o,
  input  csr_pkg::csr_rport_t    regfile_rport_i,
  input  csr_pkg::csr_rport_t    counter_rport_i,
  output csr_pkg::csr_wport_t    wport_o
);

  csr_pkg::csr_state_e state_q;
  csr_pkg::csr_state_e state_d;

  logic                 ack_q;
  logic                 illegal_q;
  // old register value that doubles as the response data
  logic [`CSR_XLEN-1:0] old_q;

  logic                 any_hit;
  logic                 ro_space;
  logic                 illegal;
  logic [`CSR_XLEN-1:0] merged_rdata;
  logic [`CSR_XLEN-1:0] new_value;

  // request is held stable until ack so it addresses both parts directly
  assign raddr_o = req_i.addr;

  //////////////////////////////
  // read merge and legality
  //////////////////////////////

  assign any_hit = regfile_rport_i.hit | counter_rport_i.hit;

  // top two address bits both set means read-only space
  assign ro_space = &req_i.addr[`CSR_ADDR_W-1:`CSR_ADDR_W-2];

  assign illegal = !any_hit || (ro_space && (req_i.op != csr_pkg::CSR_OP_READ));

  always_comb begin
    // at most one part claims an address
    if (regfile_rport_i.hit) begin
      merged_rdata = regfile_rport_i.rdata;
    end else if (counter_rport_i.hit) begin
      merged_rdata = counter_rport_i.rdata;
    end else begin
      merged_rdata = '0;
    end
  end

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      csr_pkg::ST_IDLE:   if (req_valid_i) state_d = csr_pkg::ST_ACCESS;
      csr_pkg::ST_ACCESS: state_d = csr_pkg::ST_DONE;
      // wait for the master to drop its request
      csr_pkg::ST_DONE:   if (!req_valid_i) state_d = csr_pkg::ST_IDLE;
      default:            state_d = csr_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= csr_pkg::ST_IDLE;
      ack_q     <= 1'b0;
      illegal_q <= 1'b0;
      old_q     <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == csr_pkg::ST_IDLE && req_valid_i) begin
        // snapshot read data at the sampling edge
        old_q     <= illegal ? '0 : merged_rdata;
        illegal_q <= illegal;
      end
      if (state_q == csr_pkg::ST_ACCESS) begin
        ack_q <= 1'b1;
      end else if (state_q == csr_pkg::ST_DONE && !req_valid_i) begin
        ack_q <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // read-modify-write
  //////////////////////////////

  always_comb begin
    case (req_i.op)
      csr_pkg::CSR_OP_WRITE: new_value = req_i.wdata;
      csr_pkg::CSR_OP_SET:   new_value = old_q | req_i.wdata;
      csr_pkg::CSR_OP_CLEAR: new_value = old_q & ~req_i.wdata;
      default:               new_value = old_q;
    endcase
  end

  // write lands on the edge that leaves ST_ACCESS
  assign wport_o.en   = (state_q == csr_pkg::ST_ACCESS) && !illegal_q
                      && (req_i.op != csr_pkg::CSR_OP_READ);
  assign wport_o.addr = req_i.addr;
  assign wport_o.data = new_value;

  assign ack_o         = ack_q;
  assign rsp_o.rdata   = old_q;
  assign rsp_o.illegal = illegal_q;

  a_ack_in_done: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o |-> state_q == csr_pkg::ST_DONE);

  // a write only reaches a register file address outside read-only space
  a_write_legal: assert property (@(posedge clk_i) disable iff (rst_i)
    wport_o.en |-> regfile_rport_i.hit && !ro_space);

endmodule

//--- csr_counters.sv
`timescale 1ns/100ps

`include "csr_defines.svh"

module csr_counters (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   retire_i,
  input  logic [`CSR_ADDR_W-1:0] raddr_i,
  output csr_pkg::csr_rport_t    rport_o
);

  // 64 bit free running counters
  logic [2*`CSR_XLEN-1:0] cycle_q;
  logic [2*`CSR_XLEN-1:0] instret_q;

  //////////////////////////////
  // count
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cycle_q   <= '0;
      instret_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
      // core pulses retire once per retired instruction
      if (retire_i) begin
        instret_q <= instret_q + 1'b1;
      end
    end
  end

  //////////////////////////////
  // read-only shadow decode
  //////////////////////////////

  always_comb begin
    rport_o.hit   = 1'b1;
    rport_o.rdata = '0;
    case (raddr_i)
      `CSR_ADDR_CYCLE:    rport_o.rdata = cycle_q[`CSR_XLEN-1:0];
      `CSR_ADDR_CYCLEH:   rport_o.rdata = cycle_q[2*`CSR_XLEN-1:`CSR_XLEN];
      `CSR_ADDR_INSTRET:  rport_o.rdata = instret_q[`CSR_XLEN-1:0];
      `CSR_ADDR_INSTRETH: rport_o.rdata = instret_q[2*`CSR_XLEN-1:`CSR_XLEN];
      default:            rport_o.hit   = 1'b0;
    endcase
  end

  // cycle only moves forward once out of reset
  a_cycle_mono: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) |-> cycle_q > $past(cycle_q));

endmodule

//--- csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// datapath and address widths
`define CSR_XLEN            32
`define CSR_ADDR_W          12

// machine mode register addresses
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MIP        12'h344

// user shadow counters, read only
`define CSR_ADDR_CYCLE      12'hC00
`define CSR_ADDR_CYCLEH     12'hC80
`define CSR_ADDR_INSTRET    12'hC02
`define CSR_ADDR_INSTRETH   12'hC82

// writable bit masks
`define CSR_MSTATUS_MASK    32'h0000_0088
`define CSR_MIE_MASK        32'h0000_0800
`define CSR_MTVEC_MASK      32'hffff_fffc

// bit positions inside mstatus, mie and mip
`define CSR_MSTATUS_MIE_BIT  3
`define CSR_MSTATUS_MPIE_BIT 7
`define CSR_EXT_IRQ_BIT      11

`endif

//--- csr_pkg.sv
`include "csr_defines.svh"

package csr_pkg;

  //////////////////////////////
  // enums
  //////////////////////////////

  // csr instruction flavour
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'd0,
    CSR_OP_WRITE = 2'd1,
    CSR_OP_SET   = 2'd2,
    CSR_OP_CLEAR = 2'd3
  } csr_op_e;

  // access controller states
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_ACCESS = 2'd1,
    ST_DONE   = 2'd2
  } csr_state_e;

  //////////////////////////////
  // structs
  //////////////////////////////

  // request from the core, 46 bits
  typedef struct packed {
    csr_op_e                 op;
    logic [`CSR_ADDR_W-1:0]  addr;
    logic [`CSR_XLEN-1:0]    wdata;
  } csr_req_t;

  // response to the core, 33 bits
  typedef struct packed {
    logic [`CSR_XLEN-1:0]    rdata;
    logic                    illegal;
  } csr_rsp_t;

  // trap entry pulse with its capture values, 97 bits
  typedef struct packed {
    logic                    valid;
    logic [`CSR_XLEN-1:0]    pc;
    logic [`CSR_XLEN-1:0]    cause;
    logic [`CSR_XLEN-1:0]    tval;
  } csr_trap_t;

  // combinational read answer from one part, 33 bits
  typedef struct packed {
    logic                    hit;
    logic [`CSR_XLEN-1:0]    rdata;
  } csr_rport_t;

  // write command into the register file, 45 bits
  typedef struct packed {
    logic                    en;
    logic [`CSR_ADDR_W-1:0]  addr;
    logic [`CSR_XLEN-1:0]    data;
  } csr_wport_t;

endpackage

//--- csr_regfile.sv
`timescale 1ns/100ps

`include "csr_defines.svh"

module csr_regfile (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic [`CSR_ADDR_W-1:0] raddr_i,
  output csr_pkg::csr_rport_t    rport_o,
  input  csr_pkg::csr_wport_t    wport_i,
  input  csr_pkg::csr_trap_t     trap_i,
  input  logic                   mret_i,
  input  logic                   ext_irq_i,
  output logic [`CSR_XLEN-1:0]   handler_addr_o,
  output logic                   irq_pending_o
);

  // machine registers
  logic [`CSR_XLEN-1:0] mtvec_q;
  logic [`CSR_XLEN-1:0] mscratch_q;
  logic [`CSR_XLEN-1:0] mepc_q;
  logic [`CSR_XLEN-1:0] mcause_q;
  logic [`CSR_XLEN-1:0] mtval_q;
  logic [`CSR_XLEN-1:0] mstatus_q;
  logic [`CSR_XLEN-1:0] mie_q;
  logic [`CSR_XLEN-1:0] handler_q;

  // next values
  logic [`CSR_XLEN-1:0] mtvec_d;
  logic [`CSR_XLEN-1:0] mscratch_d;
  logic [`CSR_XLEN-1:0] mepc_d;
  logic [`CSR_XLEN-1:0] mcause_d;
  logic [`CSR_XLEN-1:0] mtval_d;
  logic [`CSR_XLEN-1:0] mstatus_d;
  logic [`CSR_XLEN-1:0] mie_d;

  // mip is not stored, only MEIP mirrors the external line
  logic [`CSR_XLEN-1:0] mip_value;

  always_comb begin
    mip_value = '0;
    mip_value[`CSR_EXT_IRQ_BIT] = ext_irq_i;
  end

  //////////////////////////////
  // read decode
  //////////////////////////////

  always_comb begin
    rport_o.hit   = 1'b1;
    rport_o.rdata = '0;
    case (raddr_i)
      `CSR_ADDR_MSTATUS:  rport_o.rdata = mstatus_q;
      `CSR_ADDR_MIE:      rport_o.rdata = mie_q;
      `CSR_ADDR_MTVEC:    rport_o.rdata = mtvec_q;
      `CSR_ADDR_MSCRATCH: rport_o.rdata = mscratch_q;
      `CSR_ADDR_MEPC:     rport_o.rdata = mepc_q;
      `CSR_ADDR_MCAUSE:   rport_o.rdata = mcause_q;
      `CSR_ADDR_MTVAL:    rport_o.rdata = mtval_q;
      `CSR_ADDR_MIP:      rport_o.rdata = mip_value;
      // not ours, the controller decides legality
      default:            rport_o.hit   = 1'b0;
    endcase
  end

  //////////////////////////////
  // write, trap and mret
  //////////////////////////////

  always_comb begin
    mtvec_d    = mtvec_q;
    mscratch_d = mscratch_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    mtval_d    = mtval_q;
    mstatus_d  = mstatus_q;
    mie_d      = mie_q;
    if (trap_i.valid) begin
      // trap entry beats any write in the same cycle
      mepc_d   = trap_i.pc;
      mcause_d = trap_i.cause;
      mtval_d  = trap_i.tval;
      // stash MIE into MPIE and mask interrupts in the handler
      mstatus_d[`CSR_MSTATUS_MPIE_BIT] = mstatus_q[`CSR_MSTATUS_MIE_BIT];
      mstatus_d[`CSR_MSTATUS_MIE_BIT]  = 1'b0;
    end else begin
      if (wport_i.en) begin
        case (wport_i.addr)
          `CSR_ADDR_MSTATUS:  mstatus_d  = wport_i.data & `CSR_MSTATUS_MASK;
          `CSR_ADDR_MIE:      mie_d      = wport_i.data & `CSR_MIE_MASK;
          // handler base is word aligned, direct mode only
          `CSR_ADDR_MTVEC:    mtvec_d    = wport_i.data & `CSR_MTVEC_MASK;
          `CSR_ADDR_MSCRATCH: mscratch_d = wport_i.data;
          `CSR_ADDR_MEPC:     mepc_d     = wport_i.data;
          `CSR_ADDR_MCAUSE:   mcause_d   = wport_i.data;
          `CSR_ADDR_MTVAL:    mtval_d    = wport_i.data;
          // mip and anything else drop the write
          default: ;
        endcase
      end
      if (mret_i) begin
        // leave the handler, restore MIE and arm MPIE
        mstatus_d[`CSR_MSTATUS_MIE_BIT]  = mstatus_q[`CSR_MSTATUS_MPIE_BIT];
        mstatus_d[`CSR_MSTATUS_MPIE_BIT] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mstatus_q  <= '0;
      mie_q      <= '0;
      handler_q  <= '0;
    end else begin
      mtvec_q    <= mtvec_d;
      mscratch_q <= mscratch_d;
      mepc_q     <= mepc_d;
      mcause_q   <= mcause_d;
      mtval_q    <= mtval_d;
      mstatus_q  <= mstatus_d;
      mie_q      <= mie_d;
      // handler address trails mtvec by one edge
      handler_q  <= mtvec_q;
    end
  end

  assign handler_addr_o = handler_q;

  // external interrupt gated by MEIE and the global MIE
  assign irq_pending_o = ext_irq_i & mie_q[`CSR_EXT_IRQ_BIT]
                       & mstatus_q[`CSR_MSTATUS_MIE_BIT];

  // the core never enters and leaves a trap in one cycle
  a_trap_mret_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(trap_i.valid && mret_i));

endmodule

//--- csr_unit_top.sv
`timescale 1ns/100ps

`include "csr_defines.svh"

module csr_unit_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  csr_pkg::csr_req_t    csr_req_i,
  input  logic                 csr_req_valid_i,
  output logic                 csr_ack_o,
  output csr_pkg::csr_rsp_t    csr_rsp_o,
  input  csr_pkg::csr_trap_t   trap_i,
  input  logic                 mret_i,
  input  logic                 retire_i,
  input  logic                 ext_irq_i,
  output logic [`CSR_XLEN-1:0] handler_addr_o,
  output logic                 irq_pending_o
);

  // shared read address and per part answers
  logic [`CSR_ADDR_W-1:0] raddr;
  csr_pkg::csr_rport_t    regfile_rport;
  csr_pkg::csr_rport_t    counter_rport;
  csr_pkg::csr_wport_t    wport;

  csr_access_ctrl csr_access_ctrl_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_i           (csr_req_i),
    .req_valid_i     (csr_req_valid_i),
    .ack_o           (csr_ack_o),
    .rsp_o           (csr_rsp_o),
    .raddr_o         (raddr),
    .regfile_rport_i (regfile_rport),
    .counter_rport_i (counter_rport),
    .wport_o         (wport)
  );

  csr_regfile csr_regfile_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .raddr_i        (raddr),
    .rport_o        (regfile_rport),
    .wport_i        (wport),
    .trap_i         (trap_i),
    .mret_i         (mret_i),
    .ext_irq_i      (ext_irq_i),
    .handler_addr_o (handler_addr_o),
    .irq_pending_o  (irq_pending_o)
  );

  // counters only see reads, never the write port
  csr_counters csr_counters_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .retire_i (retire_i),
    .raddr_i  (raddr),
    .rport_o  (counter_rport)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# build the csr unit testbench with verilator, run it, judge the log
cd "$(dirname "$0")" &&
rm -rf obj_dir build.log sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_csr_unit -f src.f \
  > build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_csr_unit > sim.log 2>&1
grep -qx "Finished with no errors" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- src.f
+incdir+.
csr_pkg.sv
csr_regfile.sv
csr_counters.sv
csr_access_ctrl.sv
csr_unit_top.sv
tb_csr_checker.sv
tb_csr_unit.sv

//--- tb_csr_checker.sv
`timescale 1ns/100ps

`include "csr_defines.svh"

module tb_csr_checker (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 ack_i,
  input  csr_pkg::csr_rsp_t    rsp_i,
  input  csr_pkg::csr_rsp_t    exp_rsp_i,
  input  logic                 exp_care_i,
  input  logic                 irq_pending_i,
  input  logic                 irq_chk_i,
  input  logic                 exp_irq_i,
  input  logic [`CSR_XLEN-1:0] handler_addr_i,
  input  logic                 handler_chk_i,
  input  logic [`CSR_XLEN-1:0] exp_handler_i,
  output logic [31:0]          check_count_o,
  output logic [31:0]          error_count_o
);

  logic ack_prev;
  int   checks = 0;
  int   errors = 0;

  // one comparison, counted, reported on a mismatch
  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  //////////////////////////////
  // sampling
  //////////////////////////////

  always @(posedge clk_i) begin
    if (rst_i) begin
      ack_prev <= 1'b0;
    end else begin
      // response is held while ack is high, take it on the first edge
      if (ack_i && !ack_prev) begin
        compare("illegal flag", {31'b0, rsp_i.illegal}, {31'b0, exp_rsp_i.illegal});
        // base reads only care about legality
        if (exp_care_i) begin
          compare("response rdata", rsp_i.rdata, exp_rsp_i.rdata);
        end
      end
      if (irq_chk_i) begin
        compare("irq_pending", {31'b0, irq_pending_i}, {31'b0, exp_irq_i});
      end
      if (handler_chk_i) begin
        compare("handler_addr", handler_addr_i, exp_handler_i);
      end
      ack_prev <= ack_i;
    end
  end

  assign check_count_o = checks;
  assign error_count_o = errors;

endmodule

//--- tb_csr_unit.sv
`timescale 1ns/100ps

`include "csr_defines.svh"

module tb_csr_unit;

  // 93 requests with 6 cycles allowed for each and the total doubled
  localparam int REQ_COUNT      = 93;
  localparam int TIMEOUT_CYCLES = 2 * REQ_COUNT * 6;

  // model slots
  localparam int R_MSTATUS = 0;
  localparam int R_MIE     = 1;
  localparam int R_MTVEC   = 2;
  localparam int R_MEPC    = 4;
  localparam int R_MCAUSE  = 5;
  localparam int R_MTVAL   = 6;

  logic               clk = 1'b0;
  logic               rst;
  csr_pkg::csr_req_t  csr_req;
  csr_pkg::csr_rsp_t  csr_rsp;
  csr_pkg::csr_rsp_t  exp_rsp;
  csr_pkg::csr_trap_t trap;
  logic               csr_req_valid;
  logic               csr_ack;
  logic               mret;
  logic               retire;
  logic               ext_irq;
  logic               irq_pending;
  logic               exp_care;
  logic               irq_chk;
  logic               exp_irq;
  logic               handler_chk;
  logic [31:0]        handler_addr;
  logic [31:0]        exp_handler;
  logic [31:0]        check_count;
  logic [31:0]        error_count;
  logic [31:0]        lfsr_q;
  logic [31:0]        cyc;
  logic [31:0]        ack_cyc;
  logic [31:0]        got;
  logic [31:0]        base_val;
  logic [31:0]        base_cyc;
  logic [31:0]        op_start;
  int                 retire_n;
  // mstatus, mie, mtvec, mscratch, mepc, mcause, mtval
  logic [31:0]        model [0:6];

  always #10 clk = ~clk;

  csr_unit_top csr_unit_top_inst (
    .clk_i           (clk),
    .rst_i           (rst),
    .csr_req_i       (csr_req),
    .csr_req_valid_i (csr_req_valid),
    .csr_ack_o       (csr_ack),
    .csr_rsp_o       (csr_rsp),
    .trap_i          (trap),
    .mret_i          (mret),
    .retire_i        (retire),
    .ext_irq_i       (ext_irq),
    .handler_addr_o  (handler_addr),
    .irq_pending_o   (irq_pending)
  );

  tb_csr_checker tb_csr_checker_inst (
    .clk_i          (clk),
    .rst_i          (rst),
    .ack_i          (csr_ack),
    .rsp_i          (csr_rsp),
    .exp_rsp_i      (exp_rsp),
    .exp_care_i     (exp_care),
    .irq_pending_i  (irq_pending),
    .irq_chk_i      (irq_chk),
    .exp_irq_i      (exp_irq),
    .handler_addr_i (handler_addr),
    .handler_chk_i  (handler_chk),
    .exp_handler_i  (exp_handler),
    .check_count_o  (check_count),
    .error_count_o  (error_count)
  );

  // edge count out of reset that also acts as the watchdog
  always @(posedge clk) begin
    if (rst) begin
      cyc <= '0;
    end else begin
      cyc <= cyc + 32'd1;
      if (cyc >= TIMEOUT_CYCLES) begin
        $display("timeout: run still busy after %0d cycles, a handshake hung", cyc);
        $display("Finished with errors");
        $finish;
      end
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // fibonacci lfsr x^32+x^22+x^2+x+1 stepped once per bit
  function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < nbits; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      bits   = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // expected register value after an op with the register mask applied
  function automatic logic [31:0] ref_apply(input csr_pkg::csr_op_e op,
      input logic [11:0] addr, input logic [31:0] old, input logic [31:0] wdata);
    logic [31:0] val;
    case (op)
      csr_pkg::CSR_OP_WRITE: val = wdata;
      csr_pkg::CSR_OP_SET:   val = old | wdata;
      csr_pkg::CSR_OP_CLEAR: val = old & ~wdata;
      default:               val = old;
    endcase
    case (addr)
      `CSR_ADDR_MSTATUS: val = val & `CSR_MSTATUS_MASK;
      `CSR_ADDR_MIE:     val = val & `CSR_MIE_MASK;
      `CSR_ADDR_MTVEC:   val = val & `CSR_MTVEC_MASK;
      default: ;
    endcase
    return val;
  endfunction

  function automatic logic [11:0] addr_of(input int idx);
    case (idx)
      0:       return `CSR_ADDR_MSTATUS;
      1:       return `CSR_ADDR_MIE;
      2:       return `CSR_ADDR_MTVEC;
      3:       return `CSR_ADDR_MSCRATCH;
      4:       return `CSR_ADDR_MEPC;
      5:       return `CSR_ADDR_MCAUSE;
      default: return `CSR_ADDR_MTVAL;
    endcase
  endfunction

  // four-phase request with the expectation set up before valid rises
  task automatic csr_access(input csr_pkg::csr_op_e op, input logic [11:0] addr,
      input logic [31:0] wdata, input logic [31:0] exp_rdata, input logic exp_illegal,
      input logic care);
    exp_rsp.rdata   = exp_rdata;
    exp_rsp.illegal = exp_illegal;
    exp_care        = care;
    csr_req.op      = op;
    csr_req.addr    = addr;
    csr_req.wdata   = wdata;
    csr_req_valid   = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!csr_ack);
    got           = csr_rsp.rdata;
    ack_cyc       = cyc;
    csr_req_valid = 1'b0;
    while (csr_ack) begin
      @(posedge clk);
      #1;
    end
  endtask

  // op on a writable register while the model tracks the new value
  task automatic reg_op(input int idx, input csr_pkg::csr_op_e op, input logic [31:0] wdata);
    logic [31:0] old;
    old        = model[idx];
    model[idx] = ref_apply(op, addr_of(idx), old, wdata);
    csr_access(op, addr_of(idx), wdata, old, 1'b0, 1'b1);
  endtask

  // every modifying op to a read-only counter address
  task automatic write_ro(input logic [11:0] addr);
    csr_access(csr_pkg::CSR_OP_WRITE, addr, lfsr_take(32), '0, 1'b1, 1'b1);
    csr_access(csr_pkg::CSR_OP_SET, addr, lfsr_take(32), '0, 1'b1, 1'b1);
    csr_access(csr_pkg::CSR_OP_CLEAR, addr, lfsr_take(32), '0, 1'b1, 1'b1);
  endtask

  task automatic check_irq(input logic expected);
    exp_irq = expected;
    irq_chk = 1'b1;
    @(posedge clk);
    #1;
    irq_chk = 1'b0;
  endtask

  task automatic report_test(input string name);
    $display("test %s finished, errors so far %0d", name, error_count);
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    lfsr_q        = 32'h441;
    rst           = 1'b1;
    csr_req       = '0;
    csr_req_valid = 1'b0;
    trap          = '0;
    mret          = 1'b0;
    retire        = 1'b0;
    ext_irq       = 1'b0;
    exp_rsp       = '0;
    exp_care      = 1'b0;
    irq_chk       = 1'b0;
    exp_irq       = 1'b0;
    handler_chk   = 1'b0;
    exp_handler   = '0;
    for (int i = 0; i < 7; i++) begin
      model[i] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // every op on every writable register with a read back after each
    for (int r = 0; r < 7; r++) begin
      op_start = lfsr_take(2);
      for (int n = 0; n < 4; n++) begin
        reg_op(r, csr_pkg::csr_op_e'(op_start[1:0] + n[1:0]), lfsr_take(32));
        reg_op(r, csr_pkg::CSR_OP_READ, '0);
      end
    end
    report_test("register ops");

    write_ro(`CSR_ADDR_CYCLE);
    write_ro(`CSR_ADDR_INSTRET);
    write_ro(`CSR_ADDR_CYCLEH);
    write_ro(`CSR_ADDR_INSTRETH);
    // nobody decodes these
    csr_access(csr_pkg::CSR_OP_READ, 12'h7C0, '0, '0, 1'b1, 1'b1);
    csr_access(csr_pkg::CSR_OP_WRITE, 12'h123, lfsr_take(32), '0, 1'b1, 1'b1);
    // no retire yet and far below 2^32 cycles
    csr_access(csr_pkg::CSR_OP_READ, `CSR_ADDR_INSTRET, '0, '0, 1'b0, 1'b1);
    csr_access(csr_pkg::CSR_OP_READ, `CSR_ADDR_INSTRETH, '0, '0, 1'b0, 1'b1);
    csr_access(csr_pkg::CSR_OP_READ, `CSR_ADDR_CYCLEH, '0, '0, 1'b0, 1'b1);
    report_test("illegal access");

    reg_op(R_MSTATUS, csr_pkg::CSR_OP_WRITE, 32'h0000_0008);
    trap.pc          = lfsr_take(32);
    trap.cause       = lfsr_take(32);
    trap.tval        = lfsr_take(32);
    trap.valid       = 1'b1;
    model[R_MEPC]    = trap.pc;
    model[R_MCAUSE]  = trap.cause;
    model[R_MTVAL]   = trap.tval;
    // MIE moves to MPIE and MIE clears
    model[R_MSTATUS] = model[R_MSTATUS][3] ? 32'h0000_0080 : 32'h0;
    @(posedge clk);
    #1;
    trap.valid = 1'b0;
    reg_op(R_MEPC, csr_pkg::CSR_OP_READ, '0);
    reg_op(R_MCAUSE, csr_pkg::CSR_OP_READ, '0);
    reg_op(R_MTVAL, csr_pkg::CSR_OP_READ, '0);
    reg_op(R_MSTATUS, csr_pkg::CSR_OP_READ, '0);
    mret             = 1'b1;
    model[R_MSTATUS] = (model[R_MSTATUS][7] ? 32'h0000_0008 : 32'h0) | 32'h0000_0080;
    @(posedge clk);
    #1;
    mret = 1'b0;
    reg_op(R_MSTATUS, csr_pkg::CSR_OP_READ, '0);
    report_test("trap and mret");

    ext_irq = 1'b1;
    for (int c = 0; c < 4; c++) begin
      reg_op(R_MIE, csr_pkg::CSR_OP_WRITE, c[0] ? `CSR_MIE_MASK : 32'h0);
      reg_op(R_MSTATUS, csr_pkg::CSR_OP_WRITE, c[1] ? 32'h0000_0008 : 32'h0);
      check_irq(c[0] && c[1]);
    end
    csr_access(csr_pkg::CSR_OP_READ, `CSR_ADDR_MIP, '0, 32'h0000_0800, 1'b0, 1'b1);
    ext_irq = 1'b0;
    csr_access(csr_pkg::CSR_OP_READ, `CSR_ADDR_MIP, '0, '0, 1'b0, 1'b1);
    report_test("interrupt pending");

    // first cycle read is only the base
    csr_access(csr_pkg::CSR_OP_READ, `CSR_ADDR_CYCLE, '0, '0, 1'b0, 1'b0);
    base_val = got;
    base_cyc = ack_cyc;
    repeat (4 + lfsr_take(3)) @(posedge clk);
    #1;
    // ack rises two edges after valid is raised here
    csr_access(csr_pkg::CSR_OP_READ, `CSR_ADDR_CYCLE, '0,
               base_val + (cyc + 32'd2 - base_cyc), 1'b0, 1'b1);
    retire_n = 3 + lfsr_take(3);
    repeat (retire_n) begin
      retire = 1'b1;
      @(posedge clk);
      #1;
      retire = 1'b0;
      @(posedge clk);
      #1;
    end
    csr_access(csr_pkg::CSR_OP_READ, `CSR_ADDR_INSTRET, '0, retire_n, 1'b0, 1'b1);
    reg_op(R_MTVEC, csr_pkg::CSR_OP_WRITE, lfsr_take(32));
    exp_handler = model[R_MTVEC];
    handler_chk = 1'b1;
    @(posedge clk);
    #1;
    handler_chk = 1'b0;
    report_test("counters and handler");

    repeat (2) @(posedge clk);
    #1;
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
